// File: snes_mem_pkg.sv
package snes_mem_pkg;

    // address space
    localparam int addr_w        = 24;  // cartridge + work ram byte address
    localparam int wram_addr_w   = 17;  // 128k work ram
    localparam int wram_prefix_w = 7;   // fixed upper bits above work ram

    // byte address, bit 0 picks the lane
    typedef logic [addr_w-1:0] addr_t;

    // sdram word address, byte address without bit 0
    typedef logic [addr_w-2:0] word_addr_t;

    typedef logic [7:0] byte_t;

    // who issued the access
    typedef enum logic [1:0] {
        kind_load = 2'd0,  // cartridge loader write
        kind_rom  = 2'd1,  // cpu rom read
        kind_wram = 2'd2   // cpu work ram read/write
    } access_kind_t;

    // request from the console cpu, 36 bits
    typedef struct packed {
        access_kind_t kind;      // rom or wram only
        logic         write;     // wram only, rom is read only
        logic         rom_word;  // 16 bit rom fetch
        addr_t        addr;      // wram uses the low 17 bits
        byte_t        wdata;
    } cpu_cmd_t;

    // command to the sdram request port, 45 bits
    typedef struct packed {
        word_addr_t   waddr;
        logic [15:0]  din;       // byte copied to both lanes
        logic [1:0]   ds;        // lane enables, bit 1 = upper byte
        logic         rd;
        logic         wr;
        access_kind_t kind;      // steers the read data back
    } mem_cmd_t;

    // two lanes of one sdram word
    typedef struct packed {
        byte_t hi;  // odd byte address
        byte_t lo;  // even byte address
    } byte_pair_t;

    // sdram word, seen whole for rom and per lane for wram
    typedef union packed {
        logic [15:0] word;
        byte_pair_t  bytes;
    } mem_word_u;

endpackage

// File: loader_port.sv
`timescale 1ns/1ps

module loader_port (
    input  logic                wclk,
    input  logic                resetn,
    input  logic                loading,      // high for the whole cartridge load
    input  logic                ld_req,
    input  snes_mem_pkg::byte_t ld_data,
    output logic                ld_ack,
    output logic                load_valid,   // byte waiting for the arbiter
    output snes_mem_pkg::addr_t load_addr,    // where the byte goes
    output snes_mem_pkg::byte_t load_byte,
    input  logic                load_accept   // pulse, memory write done
);

    logic loading_q;  // loading one cycle ago
    logic load_start; // rising edge of loading

    assign load_start = loading && !loading_q;

    // four-phase loader handshake and address counter
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            ld_ack     <= 1'b0;
            load_valid <= 1'b0;
            load_addr  <= '0;
            loading_q  <= 1'b0;
        end else begin
            loading_q <= loading;
            if (load_valid) begin
                if (load_accept) begin  // written, ack the loader
                    load_valid <= 1'b0;
                    ld_ack     <= 1'b1;
                end
            end else if (ld_ack) begin
                if (!ld_req)
                    ld_ack <= 1'b0;     // phase 4
            end else if (ld_req) begin
                load_valid <= 1'b1;     // new byte, one cycle after req
            end

            // restart at zero for every new load
            if (load_start)
                load_addr <= '0;
            else if (load_valid && load_accept)
                load_addr <= load_addr + 24'd1;
        end
    end

    // grab the byte together with the valid rise
    always_ff @(posedge wclk) begin
        if (ld_req && !load_valid && !ld_ack)
            load_byte <= ld_data;
    end

    // byte must not move until the arbiter has taken it
    a_byte_held: assert property (@(posedge wclk) disable iff (!resetn)
        load_valid && !load_accept |=> load_valid && $stable(load_byte));

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
    parameter logic [snes_mem_pkg::wram_prefix_w-1:0] wram_prefix = 7'b1110111
) (
    input  logic                   wclk,
    input  logic                   resetn,
    input  logic                   load_valid,
    input  snes_mem_pkg::addr_t    load_addr,
    input  snes_mem_pkg::byte_t    load_byte,
    output logic                   load_accept,  // pulse back to the loader
    input  logic                   cpu_req,
    input  snes_mem_pkg::cpu_cmd_t cpu_cmd,
    output logic                   cpu_ack,
    output logic [15:0]            cpu_rdata,    // valid while cpu_ack
    output snes_mem_pkg::mem_cmd_t cmd,
    output logic                   cmd_start,
    output logic                   rom_word,     // side info for read steering
    output logic                   byte_odd,     // address bit 0 dropped by cmd
    input  logic                   cmd_done,
    input  logic [15:0]            done_data
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_busy = 2'd1;  // command at the sdram port
    localparam logic [1:0] st_ack  = 2'd2;  // finishing the source handshake

    logic [1:0]             state;
    logic                   sel_load;     // loader owns the access in flight
    snes_mem_pkg::addr_t    wram_full;    // wram address in the 24 bit space
    snes_mem_pkg::mem_cmd_t load_cmd;
    snes_mem_pkg::mem_cmd_t cpu_mem_cmd;

    assign wram_full = {wram_prefix, cpu_cmd.addr[snes_mem_pkg::wram_addr_w-1:0]};

    // loader write, one lane picked by bit 0
    always_comb begin
        load_cmd       = '0;
        load_cmd.waddr = load_addr[23:1];
        load_cmd.din   = {load_byte, load_byte};
        load_cmd.ds    = {load_addr[0], ~load_addr[0]};
        load_cmd.wr    = 1'b1;
        load_cmd.kind  = snes_mem_pkg::kind_load;
    end

    always_comb begin
        cpu_mem_cmd      = '0;
        cpu_mem_cmd.din  = {cpu_cmd.wdata, cpu_cmd.wdata};
        cpu_mem_cmd.kind = cpu_cmd.kind;
        if (cpu_cmd.kind == snes_mem_pkg::kind_wram) begin
            cpu_mem_cmd.waddr = wram_full[23:1];
            cpu_mem_cmd.ds    = {wram_full[0], ~wram_full[0]};  // single lane
            cpu_mem_cmd.rd    = ~cpu_cmd.write;
            cpu_mem_cmd.wr    = cpu_cmd.write;
        end else begin
            // rom: whole word, never written by the cpu
            cpu_mem_cmd.waddr = cpu_cmd.addr[23:1];
            cpu_mem_cmd.ds    = 2'b11;
            cpu_mem_cmd.rd    = 1'b1;
            cpu_mem_cmd.kind  = snes_mem_pkg::kind_rom;
        end
    end

    // idle / busy / ack FSM, loader first
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            state       <= st_idle;
            sel_load    <= 1'b0;
            cmd_start   <= 1'b0;
            load_accept <= 1'b0;
            cpu_ack     <= 1'b0;
        end else begin
            cmd_start <= 1'b0;  // single pulse
            case (state)
                st_idle: begin
                    if (load_valid || cpu_req) begin
                        sel_load  <= load_valid;  // cpu waits behind the loader
                        cmd_start <= 1'b1;
                        state     <= st_busy;
                    end
                end
                st_busy: begin
                    if (cmd_done) begin
                        state <= st_ack;
                        if (sel_load)
                            load_accept <= 1'b1;
                        else
                            cpu_ack <= 1'b1;
                    end
                end
                st_ack: begin
                    if (sel_load) begin
                        load_accept <= 1'b0;  // loader drops valid on the pulse
                        state       <= st_idle;
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;      // phase 4
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // command and result payload
    always_ff @(posedge wclk) begin
        if (state == st_idle) begin
            if (load_valid) begin
                cmd      <= load_cmd;
                rom_word <= 1'b0;
                byte_odd <= load_addr[0];
            end else if (cpu_req) begin
                cmd      <= cpu_mem_cmd;
                rom_word <= cpu_cmd.rom_word;
                byte_odd <= cpu_cmd.addr[0];
            end
        end
        if (state == st_busy && cmd_done && !sel_load)
            cpu_rdata <= done_data;
    end

    a_rd_wr_excl: assert property (@(posedge wclk) disable iff (!resetn)
        cmd_start |-> !(cmd.rd && cmd.wr));

endmodule

// File: sdram_port.sv
`timescale 1ns/1ps

module sdram_port (
    input  logic                   wclk,
    input  logic                   resetn,
    input  snes_mem_pkg::mem_cmd_t cmd,
    input  logic                   cmd_start,
    output logic                   cmd_done,   // pulse after mem_ack falls
    output logic [15:0]            done_data,  // steered read data
    output logic                   mem_req,
    output snes_mem_pkg::mem_cmd_t mem_cmd,
    input  logic                   mem_ack,
    input  logic [15:0]            mem_rdata,
    input  logic                   rom_word,
    input  logic                   byte_odd
);

    logic                    draining;  // ack seen, waiting for it to drop
    snes_mem_pkg::mem_word_u rdata_q;   // word as returned by the sdram
    logic [15:0]             steered;

    // decode the word per access kind
    always_comb begin
        case (mem_cmd.kind)
            snes_mem_pkg::kind_rom: begin
                if (rom_word || !byte_odd)
                    steered = rdata_q.word;
                else
                    steered = {rdata_q.bytes.lo, rdata_q.bytes.hi};  // odd byte fetch
            end
            snes_mem_pkg::kind_wram: begin
                // only the addressed lane, zero extended
                steered = {8'h00, byte_odd ? rdata_q.bytes.hi : rdata_q.bytes.lo};
            end
            default: steered = '0;  // loader writes return nothing
        endcase
        if (mem_cmd.wr)
            steered = '0;  // no data on writes
    end

    // four-phase exchange with the sdram controller
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            mem_req  <= 1'b0;
            draining <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (cmd_start) begin
                mem_req <= 1'b1;             // one cycle after start
            end else if (mem_req && mem_ack) begin
                mem_req  <= 1'b0;            // phase 3
                draining <= 1'b1;
            end else if (draining && !mem_ack) begin
                draining <= 1'b0;
                cmd_done <= 1'b1;            // back to the arbiter
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (cmd_start)
            mem_cmd <= cmd;
        if (mem_req && mem_ack)
            rdata_q.word <= mem_rdata;  // data valid with ack
        if (draining && !mem_ack)
            done_data <= steered;
    end

    // the controller may sample the command any time during req
    a_cmd_stable: assert property (@(posedge wclk) disable iff (!resetn)
        mem_req |=> !mem_req || $stable(mem_cmd));

    // new request only once the last ack is gone
    a_req_after_ack: assert property (@(posedge wclk) disable iff (!resetn)
        $rose(mem_req) |-> !mem_ack);

endmodule

// File: snes_mem_top.sv
`timescale 1ns/1ps

module snes_mem_top #(
    parameter logic [snes_mem_pkg::wram_prefix_w-1:0] wram_prefix = 7'b1110111
) (
    input  logic                   wclk,
    input  logic                   resetn,
    // cartridge loader
    input  logic                   loading,
    input  logic                   ld_req,
    input  snes_mem_pkg::byte_t    ld_data,
    output logic                   ld_ack,
    output snes_mem_pkg::addr_t    load_addr,
    // console cpu
    input  logic                   cpu_req,
    input  snes_mem_pkg::cpu_cmd_t cpu_cmd,
    output logic                   cpu_ack,
    output logic [15:0]            cpu_rdata,
    // sdram request port
    output logic                   mem_req,
    output snes_mem_pkg::mem_cmd_t mem_cmd,
    input  logic                   mem_ack,
    input  logic [15:0]            mem_rdata
);

    logic                   load_valid;
    snes_mem_pkg::byte_t    load_byte;
    logic                   load_accept;
    snes_mem_pkg::mem_cmd_t cmd;
    logic                   cmd_start;
    logic                   cmd_done;
    logic [15:0]            done_data;
    logic                   rom_word;   // read steering info
    logic                   byte_odd;

    loader_port i_loader (
        .wclk(wclk), .resetn(resetn), .loading(loading),
        .ld_req(ld_req), .ld_data(ld_data), .ld_ack(ld_ack),
        .load_valid(load_valid), .load_addr(load_addr), .load_byte(load_byte),
        .load_accept(load_accept)
    );

    mem_arbiter #(.wram_prefix(wram_prefix)) i_arb (
        .wclk(wclk), .resetn(resetn),
        .load_valid(load_valid), .load_addr(load_addr), .load_byte(load_byte),
        .load_accept(load_accept),
        .cpu_req(cpu_req), .cpu_cmd(cpu_cmd), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .cmd(cmd), .cmd_start(cmd_start), .rom_word(rom_word), .byte_odd(byte_odd),
        .cmd_done(cmd_done), .done_data(done_data)
    );

    sdram_port i_sdram (
        .wclk(wclk), .resetn(resetn),
        .cmd(cmd), .cmd_start(cmd_start), .cmd_done(cmd_done), .done_data(done_data),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .rom_word(rom_word), .byte_odd(byte_odd)
    );

endmodule

// File: tb_snes_mem.sv
`timescale 1ns/1ps

module tb_snes_mem;

    localparam logic [6:0] wram_prefix = 7'b1110111;
    localparam int max_cycles = 20000;  // about 400 transfers of up to 30 cycles plus margin

    logic                   wclk = 1'b0;
    logic                   resetn;
    logic                   loading;
    logic                   ld_req;
    logic                   ld_ack;
    snes_mem_pkg::byte_t    ld_data;
    snes_mem_pkg::addr_t    load_addr;
    logic                   cpu_req;
    logic                   cpu_ack;
    snes_mem_pkg::cpu_cmd_t cpu_cmd;
    logic [15:0]            cpu_rdata;
    logic                   mem_req;
    logic                   mem_ack;
    snes_mem_pkg::mem_cmd_t mem_cmd;
    logic [15:0]            mem_rdata;

    logic [15:0] mem [0:2**17-1];     // {is_wram, word addr[15:0]}
    logic [7:0]  shadow [0:2**18-1];  // {is_wram, byte addr[16:0]}
    logic [15:0] exp_q[$];            // expected read data in request order
    logic        is_rd_q[$];
    logic        cpu_ack_q = 1'b0;
    int          errors = 0;
    int          tests = 0;
    int          cycles = 0;
    int          n_req = 0;           // cpu requests issued
    int          n_ack = 0;           // cpu_ack rising edges seen
    int          ld_next = 0;         // where the next loader byte should land

    always #5 wclk = ~wclk;

    snes_mem_top #(.wram_prefix(wram_prefix)) i_dut (.*);

    // unwritten words get a pattern from every address bit
    function automatic logic [15:0] fill_word(logic [16:0] idx);
        return {idx[7:0], idx[15:8]} ^ (idx[16] ? 16'h5ac3 : 16'h3c96);
    endfunction

    // expected cpu_rdata from the shadow bytes
    function automatic logic [15:0] expect_rdata(snes_mem_pkg::cpu_cmd_t c);
        logic [16:0] even;
        even = {c.addr[16:1], 1'b0};
        if (c.kind == snes_mem_pkg::kind_wram)
            return {8'h00, shadow[{1'b1, c.addr[16:0]}]};  // prefix implied by bit 17
        if (c.rom_word || !c.addr[0])
            return {shadow[{1'b0, even | 17'd1}], shadow[{1'b0, even}]};
        return {shadow[{1'b0, even}], shadow[{1'b0, even | 17'd1}]};  // odd byte swaps
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_start) ? "pass" : "fail");
    endtask

    task automatic send_load_byte(input logic [7:0] b);
        @(negedge wclk);
        ld_data = b;
        ld_req  = 1'b1;
        shadow[{1'b0, ld_next[16:0]}] = b;
        ld_next++;
        while (!ld_ack) @(negedge wclk);
        ld_req = 1'b0;                      // phase 3
        while (ld_ack) @(negedge wclk);
    endtask

    task automatic cpu_access(input snes_mem_pkg::access_kind_t kind, input logic wr,
                              input logic word, input logic [23:0] addr,
                              input logic [7:0] wd);
        @(negedge wclk);
        cpu_cmd.kind     = kind;
        cpu_cmd.write    = wr;
        cpu_cmd.rom_word = word;
        cpu_cmd.addr     = addr;
        cpu_cmd.wdata    = wd;
        cpu_req          = 1'b1;
        exp_q.push_back(expect_rdata(cpu_cmd));
        is_rd_q.push_back(!wr);
        if (wr)
            shadow[{1'b1, addr[16:0]}] = wd;
        n_req++;
        while (!cpu_ack) @(negedge wclk);
        cpu_req = 1'b0;
        while (cpu_ack) @(negedge wclk);
    endtask

    // all 32 loaded rom words
    task automatic rom_sweep();
        for (int w = 0; w < 32; w++)
            cpu_access(snes_mem_pkg::kind_rom, 1'b0, 1'b1, 24'(2 * w), 8'h00);
    endtask

    // compares every read result as cpu_ack rises
    always @(negedge wclk) begin : ack_checker
        logic [15:0] exp_val;
        logic        rd;
        cpu_ack_q <= cpu_ack;
        if (cpu_ack && !cpu_ack_q) begin
            n_ack++;
            if (exp_q.size() == 0) begin
                $display("cpu_ack rose with no cpu request outstanding");
                errors++;
            end else begin
                exp_val = exp_q.pop_front();
                rd      = is_rd_q.pop_front();
                if (rd)
                    check_val("cpu_rdata", cpu_rdata, exp_val);
            end
        end
    end

    // sdram model answering after 1 to 4 cycles
    always begin : mem_model
        logic [16:0]                idx;
        logic                       is_wram;
        snes_mem_pkg::access_kind_t exp_kind;
        @(negedge wclk);
        if (resetn && mem_req && !mem_ack) begin
            is_wram = (mem_cmd.waddr[22:16] == wram_prefix);
            idx     = {is_wram, mem_cmd.waddr[15:0]};
            if (!is_wram && mem_cmd.waddr[22:16] != 7'd0) begin
                $display("memory access outside ROM and work RAM at word %h", mem_cmd.waddr);
                errors++;
            end
            // rom space is written only by the loader
            exp_kind = is_wram ? snes_mem_pkg::kind_wram
                     : (mem_cmd.wr ? snes_mem_pkg::kind_load : snes_mem_pkg::kind_rom);
            check_val("mem_cmd.kind", mem_cmd.kind, exp_kind);
            check_val("mem_cmd.rd", mem_cmd.rd, !mem_cmd.wr);  // exactly one of rd and wr
            repeat ($urandom_range(4, 1)) @(negedge wclk);
            if (mem_cmd.wr && mem_cmd.ds[1])
                mem[idx][15:8] = mem_cmd.din[15:8];
            if (mem_cmd.wr && mem_cmd.ds[0])
                mem[idx][7:0] = mem_cmd.din[7:0];
            mem_rdata = mem[idx];
            mem_ack   = 1'b1;
            while (mem_req) @(negedge wclk);
            mem_ack = 1'b0;                 // phase 4
        end
    end

    always @(posedge wclk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run hung waiting for an acknowledge after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : main
        int          e;
        int          r0;
        int          a0;
        int          seed;
        logic [23:0] wa [0:15];  // work ram addresses with random upper bits
        seed      = $urandom(32'hf9d9);
        resetn    = 1'b0;
        loading   = 1'b0;
        ld_req    = 1'b0;
        ld_data   = '0;
        cpu_req   = 1'b0;
        cpu_cmd   = '0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 2**17; i++) begin
            mem[i] = fill_word(17'(i));
            shadow[2 * i]     = mem[i][7:0];
            shadow[2 * i + 1] = mem[i][15:8];
        end
        repeat (8) @(negedge wclk);
        resetn = 1'b1;

        e = errors;
        check_val("ld_ack", ld_ack, 0);
        check_val("cpu_ack", cpu_ack, 0);
        check_val("mem_req", mem_req, 0);
        check_val("load_addr", load_addr, 0);
        end_test("reset state", e);

        e = errors;
        @(negedge wclk);
        loading = 1'b1;
        ld_next = 0;
        repeat (2) @(negedge wclk);
        for (int i = 0; i < 64; i++)
            send_load_byte(8'($urandom));
        check_val("load_addr", load_addr, 64);
        rom_sweep();
        end_test("load 64 bytes", e);

        e = errors;
        for (int i = 0; i < 24; i++)  // byte mode reads at both parities
            cpu_access(snes_mem_pkg::kind_rom, 1'b0, 1'b0, 24'($urandom_range(63, 0)), 8'h00);
        end_test("rom byte reads", e);

        e = errors;
        for (int i = 0; i < 16; i++) begin
            wa[i] = 24'($urandom);
            cpu_access(snes_mem_pkg::kind_wram, 1'b1, 1'b0, wa[i], 8'($urandom));
        end
        for (int i = 0; i < 16; i++)
            cpu_access(snes_mem_pkg::kind_wram, 1'b0, 1'b0, wa[i], 8'h00);
        rom_sweep();  // rom bytes untouched
        end_test("work ram write/read", e);

        e = errors;
        @(negedge wclk);
        loading = 1'b0;
        repeat (4) @(negedge wclk);
        loading = 1'b1;  // counter restarts
        ld_next = 0;
        repeat (2) @(negedge wclk);
        for (int i = 0; i < 8; i++)
            send_load_byte(8'($urandom));
        check_val("load_addr", load_addr, 8);
        rom_sweep();
        end_test("reload", e);

        e  = errors;
        r0 = n_req;
        a0 = n_ack;
        fork
            for (int k = 0; k < 16; k++)
                send_load_byte(8'($urandom));  // bytes 8..23
            for (int k = 0; k < 24; k++) begin
                if (k % 3 == 2)  // upper rom half away from the loader
                    cpu_access(snes_mem_pkg::kind_rom, 1'b0, 1'($urandom),
                               24'(32 + $urandom_range(31, 0)), 8'h00);
                else
                    cpu_access(snes_mem_pkg::kind_wram, k % 3 == 0, 1'b0, wa[k % 16],
                               8'($urandom));
            end
        join
        check_val("cpu_ack count", n_ack - a0, n_req - r0);
        check_val("load_addr", load_addr, 24);
        rom_sweep();
        for (int i = 0; i < 16; i++)
            cpu_access(snes_mem_pkg::kind_wram, 1'b0, 1'b0, wa[i], 8'h00);
        end_test("cpu during load", e);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: compile.f
snes_mem_pkg.sv
loader_port.sv
mem_arbiter.sv
sdram_port.sv
snes_mem_top.sv
tb_snes_mem.sv

// File: Bender.yml
package:
  name: snes_mem

sources:
  - snes_mem_pkg.sv
  - loader_port.sv
  - mem_arbiter.sv
  - sdram_port.sv
  - snes_mem_top.sv
  - target: test
    files:
      - tb_snes_mem.sv
